// File: src/pinmux_pkg.sv
// Register bus widths, word address map, chip identity and shared struct types

package pinmux_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned data_w    = 32;
  localparam int unsigned addr_w    = 5;
  localparam int unsigned be_w      = 4;
  localparam int unsigned gpio_w    = 32;
  localparam int unsigned hw_intr_w = 8;

  // --------------------------------------------------------------------------
  // Word address map
  // --------------------------------------------------------------------------
  // Global bank
  localparam logic [addr_w-1:0] addr_chip_id   = 5'd0;
  localparam logic [addr_w-1:0] addr_glbl_ctrl = 5'd1;
  localparam logic [addr_w-1:0] addr_glbl_mask = 5'd3;
  localparam logic [addr_w-1:0] addr_glbl_stat = 5'd4;
  // GPIO bank
  localparam logic [addr_w-1:0] addr_gpio_in   = 5'd5;
  localparam logic [addr_w-1:0] addr_gpio_out  = 5'd6;
  localparam logic [addr_w-1:0] addr_gpio_dir  = 5'd7;
  localparam logic [addr_w-1:0] addr_gpio_type = 5'd8;
  localparam logic [addr_w-1:0] addr_gpio_stat = 5'd9;
  localparam logic [addr_w-1:0] addr_gpio_set  = 5'd10;
  localparam logic [addr_w-1:0] addr_gpio_mask = 5'd11;
  localparam logic [addr_w-1:0] addr_gpio_pos  = 5'd12;
  localparam logic [addr_w-1:0] addr_gpio_neg  = 5'd13;

  // Manufacturer code, core count, chip number, revision
  localparam logic [data_w-1:0] chip_id_value = {16'h8268, 4'h2, 4'h3, 8'h01};

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------
  typedef logic [data_w-1:0] word_t;

  // One bus request, held by the master until ack
  typedef struct packed {
    logic              cs;
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [be_w-1:0]   be;
    word_t             wdata;
  } reg_req_t;

  // Reset outputs, all active low
  typedef struct packed {
    logic       cpu_intf_rst_n;
    logic       qspim_rst_n;
    logic       sspim_rst_n;
    logic [1:0] uart_rst_n;
    logic       i2cm_rst_n;
    logic       usb_rst_n;
    logic [3:0] cpu_core_rst_n;
  } rst_ctrl_t;

  // Declared MSB first, so timer_intr lands in bits 2:0
  typedef struct packed {
    logic       gpio_intr;
    logic [1:0] ext_intr;
    logic       usb_intr;
    logic       i2cm_intr;
    logic [2:0] timer_intr;
  } hw_intr_t;

  // Same bit order as status bits 19:0
  typedef struct packed {
    logic [2:0]  user_irq;
    logic        soft_irq;
    logic [15:0] irq_lines;
  } irq_out_t;

  // GPIO pad control configuration
  typedef struct packed {
    logic [gpio_w-1:0] out_data;
    logic [gpio_w-1:0] dir_sel;
    logic [gpio_w-1:0] out_type;
    logic [gpio_w-1:0] posedge_sel;
    logic [gpio_w-1:0] negedge_sel;
    logic [gpio_w-1:0] data_in;
    logic [gpio_w-1:0] prev_indata;
  } gpio_cfg_t;

  // Byte-enabled merge of write data into a register word
  function automatic word_t be_merge(word_t cur, word_t wdata, logic [be_w-1:0] be);
    word_t res;
    res = cur;
    for (int i = 0; i < be_w; i++) begin
      if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

endpackage

// File: src/intr_stat_reg.sv
// Sticky interrupt status register with write-one-to-clear, type parameterised

`timescale 1ns/1ps

module intr_stat_reg
  import pinmux_pkg::*;
#(
  parameter type stat_t = word_t
) (
  input  logic  mclk,
  input  logic  h_reset_n,
  input  stat_t clr_we,
  input  stat_t clr_din,
  input  stat_t hw_req,
  output stat_t stat
);

  // Bits cleared by software this cycle
  stat_t clr_mask;

  // Clear needs both the byte strobe and a one in the data
  assign clr_mask = clr_we & clr_din;

  // --------------------------------------------------------------------------
  // Status update
  // --------------------------------------------------------------------------
  // Set has priority over clear on the same bit
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      stat <= '0;
    end else begin
      stat <= hw_req | (stat & ~clr_mask);
    end
  end

endmodule

// File: src/glbl_ctrl_bank.sv
// Global bank with chip identity, control, interrupt mask, status and CPU irq outputs

`timescale 1ns/1ps

module glbl_ctrl_bank
  import pinmux_pkg::*;
(
  input  logic      mclk,
  input  logic      h_reset_n,
  input  reg_req_t  reg_req,
  input  logic      bus_ack,
  input  hw_intr_t  hw_intr,
  output rst_ctrl_t rst_ctrl,
  output irq_out_t  irq_out,
  output word_t     rd_data
);

  logic                 wr_en;
  word_t                ctrl_q;
  word_t                mask_q;
  logic [7:0]           sw_lo_q;
  logic [3:0]           sw_hi_q;
  logic [hw_intr_w-1:0] hw_req;
  logic [hw_intr_w-1:0] hw_clr_we;
  logic [hw_intr_w-1:0] hw_stat;
  word_t                stat_word;

  assign wr_en = reg_req.cs & reg_req.wr;

  // --------------------------------------------------------------------------
  // Control, mask and software status bits
  // --------------------------------------------------------------------------
  // Written on every cycle of the request, same data each time
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      ctrl_q  <= '0;
      mask_q  <= '0;
      sw_lo_q <= '0;
      sw_hi_q <= '0;
    end else if (wr_en) begin
      if (reg_req.addr == addr_glbl_ctrl) begin
        ctrl_q <= be_merge(ctrl_q, reg_req.wdata, reg_req.be);
      end
      if (reg_req.addr == addr_glbl_mask) begin
        mask_q <= be_merge(mask_q, reg_req.wdata, reg_req.be);
      end
      // Status byte 0 and bits 19:16 are plain software bits
      if (reg_req.addr == addr_glbl_stat && reg_req.be[0]) begin
        sw_lo_q <= reg_req.wdata[7:0];
      end
      if (reg_req.addr == addr_glbl_stat && reg_req.be[2]) begin
        sw_hi_q <= reg_req.wdata[19:16];
      end
    end
  end

  // Hardware sources into status byte 1
  assign hw_req    = hw_intr;
  // Clear only on the ack cycle so it acts once
  assign hw_clr_we = {hw_intr_w{wr_en & bus_ack & reg_req.be[1] &
                                (reg_req.addr == addr_glbl_stat)}};

  intr_stat_reg #(
    .stat_t (logic [hw_intr_w-1:0])
  ) u_hw_stat (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .clr_we    (hw_clr_we),
    .clr_din   (reg_req.wdata[15:8]),
    .hw_req    (hw_req),
    .stat      (hw_stat)
  );

  // Upper twelve bits read zero
  assign stat_word = {12'h000, sw_hi_q, hw_stat, sw_lo_q};

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  // Peripheral resets from bits 6:0, core resets from bits 11:8
  always_comb begin
    rst_ctrl.cpu_intf_rst_n = ctrl_q[0];
    rst_ctrl.qspim_rst_n    = ctrl_q[1];
    rst_ctrl.sspim_rst_n    = ctrl_q[2];
    rst_ctrl.uart_rst_n     = {ctrl_q[6], ctrl_q[3]};
    rst_ctrl.i2cm_rst_n     = ctrl_q[4];
    rst_ctrl.usb_rst_n      = ctrl_q[5];
    rst_ctrl.cpu_core_rst_n = ctrl_q[11:8];
  end

  // Lines, soft and user irq all follow mask AND status
  assign irq_out = irq_out_t'(mask_q[19:0] & stat_word[19:0]);

  // Read mux, zero outside this bank
  always_comb begin
    rd_data = '0;
    case (reg_req.addr)
      addr_chip_id:   rd_data = chip_id_value;
      addr_glbl_ctrl: rd_data = ctrl_q;
      addr_glbl_mask: rd_data = mask_q;
      addr_glbl_stat: rd_data = stat_word;
      default:        rd_data = '0;
    endcase
  end

endmodule

// File: src/gpio_cfg_bank.sv
// GPIO bank with input synchroniser, pad configuration and GPIO interrupt status

`timescale 1ns/1ps

module gpio_cfg_bank
  import pinmux_pkg::*;
(
  input  logic      mclk,
  input  logic      h_reset_n,
  input  reg_req_t  reg_req,
  input  logic      bus_ack,
  input  word_t     gpio_in_data,
  input  word_t     gpio_int_event,
  output gpio_cfg_t gpio_cfg,
  output logic      gpio_intr,
  output word_t     rd_data
);

  logic  wr_en;
  // Three synchroniser stages
  word_t in_s1;
  word_t in_s2;
  word_t in_s3;
  // Configuration registers
  word_t out_q;
  word_t dir_q;
  word_t type_q;
  word_t mask_q;
  word_t pos_q;
  word_t neg_q;
  // Interrupt status
  logic  stat_clr_hit;
  logic  stat_set_hit;
  word_t stat_clr_we;
  word_t stat_set;
  word_t stat;

  assign wr_en = reg_req.cs & reg_req.wr;

  // --------------------------------------------------------------------------
  // Pin synchroniser
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      in_s1 <= '0;
      in_s2 <= '0;
      in_s3 <= '0;
    end else begin
      in_s1 <= gpio_in_data;
      in_s2 <= in_s1;
      in_s3 <= in_s2;
    end
  end

  // --------------------------------------------------------------------------
  // Configuration registers
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      out_q  <= '0;
      dir_q  <= '0;
      type_q <= '0;
      mask_q <= '0;
      pos_q  <= '0;
      neg_q  <= '0;
    end else if (wr_en) begin
      case (reg_req.addr)
        addr_gpio_out:  out_q  <= be_merge(out_q, reg_req.wdata, reg_req.be);
        addr_gpio_dir:  dir_q  <= be_merge(dir_q, reg_req.wdata, reg_req.be);
        addr_gpio_type: type_q <= be_merge(type_q, reg_req.wdata, reg_req.be);
        addr_gpio_mask: mask_q <= be_merge(mask_q, reg_req.wdata, reg_req.be);
        addr_gpio_pos:  pos_q  <= be_merge(pos_q, reg_req.wdata, reg_req.be);
        addr_gpio_neg:  neg_q  <= be_merge(neg_q, reg_req.wdata, reg_req.be);
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Interrupt status
  // --------------------------------------------------------------------------
  // Set and clear strobes act only on the ack cycle
  assign stat_clr_hit = wr_en & bus_ack & (reg_req.addr == addr_gpio_stat);
  assign stat_set_hit = wr_en & bus_ack & (reg_req.addr == addr_gpio_set);

  // Each byte clears under its own enable
  always_comb begin
    for (int i = 0; i < be_w; i++) begin
      stat_clr_we[8*i +: 8] = {8{stat_clr_hit & reg_req.be[i]}};
    end
  end

  // Pad events plus software set
  assign stat_set = gpio_int_event | ({data_w{stat_set_hit}} & reg_req.wdata);

  intr_stat_reg #(
    .stat_t (word_t)
  ) u_gpio_stat (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .clr_we    (stat_clr_we),
    .clr_din   (reg_req.wdata),
    .hw_req    (stat_set),
    .stat      (stat)
  );

  // Summary interrupt to the global bank
  assign gpio_intr = |(stat & mask_q);

  // --------------------------------------------------------------------------
  // Outputs and read mux
  // --------------------------------------------------------------------------
  always_comb begin
    gpio_cfg.out_data    = out_q;
    gpio_cfg.dir_sel     = dir_q;
    gpio_cfg.out_type    = type_q;
    gpio_cfg.posedge_sel = pos_q;
    gpio_cfg.negedge_sel = neg_q;
    gpio_cfg.data_in     = in_s3;
    gpio_cfg.prev_indata = in_s2;
  end

  always_comb begin
    rd_data = '0;
    case (reg_req.addr)
      addr_gpio_in:                  rd_data = in_s3;
      addr_gpio_out:                 rd_data = out_q;
      addr_gpio_dir:                 rd_data = dir_q;
      addr_gpio_type:                rd_data = type_q;
      addr_gpio_stat, addr_gpio_set: rd_data = stat;
      addr_gpio_mask:                rd_data = mask_q;
      addr_gpio_pos:                 rd_data = pos_q;
      addr_gpio_neg:                 rd_data = neg_q;
      default:                       rd_data = '0;
    endcase
  end

endmodule

// File: src/reg_bus_resp.sv
// Bus responder merging bank read data and timing the acknowledge pulse

`timescale 1ns/1ps

module reg_bus_resp
  import pinmux_pkg::*;
(
  input  logic     mclk,
  input  logic     h_reset_n,
  input  reg_req_t reg_req,
  input  word_t    glbl_rd_data,
  input  word_t    gpio_rd_data,
  output word_t    reg_rdata,
  output logic     reg_ack
);

  // Banks return zero outside their range
  word_t rd_mux;
  // New request seen, not yet acknowledged
  logic  req_new;

  assign rd_mux  = glbl_rd_data | gpio_rd_data;
  assign req_new = reg_req.cs & ~reg_ack;

  // --------------------------------------------------------------------------
  // Ack and read data capture
  // --------------------------------------------------------------------------
  // One-cycle ack, every second cycle if cs stays high
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack   <= 1'b0;
      reg_rdata <= '0;
    end else begin
      reg_ack <= req_new;
      // Read data holds until the next ack
      if (req_new) begin
        reg_rdata <= rd_mux;
      end
    end
  end

endmodule

// File: src/pinmux_regs.sv
// Top level joining the global bank, the GPIO bank and the bus responder

`timescale 1ns/1ps

module pinmux_regs
  import pinmux_pkg::*;
(
  input  logic      mclk,
  input  logic      h_reset_n,
  input  reg_req_t  reg_req,
  output word_t     reg_rdata,
  output logic      reg_ack,
  input  word_t     gpio_in_data,
  input  word_t     gpio_int_event,
  input  hw_intr_t  hw_src,
  output rst_ctrl_t rst_ctrl,
  output irq_out_t  irq_out,
  output gpio_cfg_t gpio_cfg
);

  word_t    glbl_rd_data;
  word_t    gpio_rd_data;
  logic     gpio_intr;
  hw_intr_t glbl_hw_intr;

  // GPIO summary replaces the gpio_intr field of hw_src
  always_comb begin
    glbl_hw_intr           = hw_src;
    glbl_hw_intr.gpio_intr = gpio_intr;
  end

  // --------------------------------------------------------------------------
  // Banks
  // --------------------------------------------------------------------------
  glbl_ctrl_bank u_glbl_ctrl_bank (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_req   (reg_req),
    .bus_ack   (reg_ack),
    .hw_intr   (glbl_hw_intr),
    .rst_ctrl  (rst_ctrl),
    .irq_out   (irq_out),
    .rd_data   (glbl_rd_data)
  );

  gpio_cfg_bank u_gpio_cfg_bank (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .reg_req        (reg_req),
    .bus_ack        (reg_ack),
    .gpio_in_data   (gpio_in_data),
    .gpio_int_event (gpio_int_event),
    .gpio_cfg       (gpio_cfg),
    .gpio_intr      (gpio_intr),
    .rd_data        (gpio_rd_data)
  );

  // Bus responder
  reg_bus_resp u_reg_bus_resp (
    .mclk         (mclk),
    .h_reset_n    (h_reset_n),
    .reg_req      (reg_req),
    .glbl_rd_data (glbl_rd_data),
    .gpio_rd_data (gpio_rd_data),
    .reg_rdata    (reg_rdata),
    .reg_ack      (reg_ack)
  );

endmodule

// File: bench/pinmux_regs_assertions.sv
// Bound assertions on acknowledge timing and on reset and irq outputs during reset

`timescale 1ns/1ps

module pinmux_regs_assertions
  import pinmux_pkg::*;
(
  input logic      mclk,
  input logic      h_reset_n,
  input reg_req_t  reg_req,
  input logic      reg_ack,
  input rst_ctrl_t rst_ctrl,
  input irq_out_t  irq_out
);

  // --------------------------------------------------------------------------
  // Bus acknowledge
  // --------------------------------------------------------------------------
  // One-cycle pulse only
  ack_single: assert property (@(posedge mclk) disable iff (!h_reset_n)
    reg_ack |=> !reg_ack)
    else $error("reg_ack high for two cycles in a row");

  // Ack answers a select seen one cycle earlier
  ack_after_cs: assert property (@(posedge mclk) disable iff (!h_reset_n)
    $rose(reg_ack) |-> $past(reg_req.cs))
    else $error("reg_ack rose without cs in the previous cycle");

  // --------------------------------------------------------------------------
  // Reset state
  // --------------------------------------------------------------------------
  outputs_in_reset: assert property (@(posedge mclk)
    !h_reset_n |-> (rst_ctrl == '0 && irq_out == '0))
    else $error("reset or irq outputs not zero while in reset");

endmodule

bind pinmux_regs pinmux_regs_assertions u_pinmux_regs_assertions (
  .mclk      (mclk),
  .h_reset_n (h_reset_n),
  .reg_req   (reg_req),
  .reg_ack   (reg_ack),
  .rst_ctrl  (rst_ctrl),
  .irq_out   (irq_out)
);

// File: bench/pinmux_regs_tb.sv
// Testbench for pinmux_regs with stimulus table, reference model, compare tasks and watchdog

`timescale 1ns/1ps

module pinmux_regs_tb
  import pinmux_pkg::*;
();

  // Table operation codes
  localparam logic [2:0] op_wr  = 3'd0;
  localparam logic [2:0] op_rd  = 3'd1;
  localparam logic [2:0] op_pin = 3'd2;
  localparam logic [2:0] op_evt = 3'd3;
  localparam logic [2:0] op_src = 3'd4;

  localparam int clk_half_ns  = 20;
  localparam int clk_ns       = 40;
  localparam int reset_cycles = 4;
  // Worst case cycles spent on one table entry
  localparam int step_budget  = 8;
  localparam int ack_limit    = 16;

  // One table entry
  typedef struct packed {
    logic [2:0]        op;
    logic [addr_w-1:0] addr;
    logic [be_w-1:0]   be;
    word_t             data;
    word_t             exp;
    logic              rnd;
    logic              use_model;
  } step_t;

  logic      mclk;
  logic      h_reset_n;
  reg_req_t  reg_req;
  word_t     reg_rdata;
  logic      reg_ack;
  word_t     gpio_in_data;
  word_t     gpio_int_event;
  hw_intr_t  hw_src;
  rst_ctrl_t rst_ctrl;
  irq_out_t  irq_out;
  gpio_cfg_t gpio_cfg;

  step_t       steps[$];
  logic        table_ready;
  int          errors;
  int          checks;
  logic [31:0] lfsr_state;

  // Reference model of the register state
  word_t      model_reg [32];
  logic [7:0] model_sw_lo;
  logic [3:0] model_sw_hi;
  logic [7:0] model_hw_stat;
  word_t      model_pstat;
  word_t      model_pin;
  logic [7:0] model_src;

  pinmux_regs pinmux_regs_inst (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .reg_req        (reg_req),
    .reg_rdata      (reg_rdata),
    .reg_ack        (reg_ack),
    .gpio_in_data   (gpio_in_data),
    .gpio_int_event (gpio_int_event),
    .hw_src         (hw_src),
    .rst_ctrl       (rst_ctrl),
    .irq_out        (irq_out),
    .gpio_cfg       (gpio_cfg)
  );

  always #clk_half_ns mclk = ~mclk;

  // --------------------------------------------------------------------------
  // Random data and model helpers
  // --------------------------------------------------------------------------
  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int b = 0; b < data_w; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[data_w-2:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic word_t merge_bytes(input word_t old_val, input word_t wdata,
                                        input logic [be_w-1:0] be);
    word_t res;
    res = old_val;
    for (int i = 0; i < be_w; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic word_t model_read(input logic [addr_w-1:0] addr);
    case (addr)
      addr_chip_id:                  return 32'h8268_2301;
      addr_glbl_stat:                return {12'h000, model_sw_hi, model_hw_stat, model_sw_lo};
      addr_gpio_in:                  return model_pin;
      addr_gpio_stat, addr_gpio_set: return model_pstat;
      addr_glbl_ctrl, addr_glbl_mask, addr_gpio_out, addr_gpio_dir, addr_gpio_type,
      addr_gpio_mask, addr_gpio_pos, addr_gpio_neg: return model_reg[addr];
      default:                       return '0;
    endcase
  endfunction

  // Reset bits from control bits 6:0 and 11:8
  function automatic rst_ctrl_t expected_rst();
    rst_ctrl_t e;
    word_t     c;
    c = model_reg[addr_glbl_ctrl];
    e.cpu_intf_rst_n = c[0];
    e.qspim_rst_n    = c[1];
    e.sspim_rst_n    = c[2];
    e.uart_rst_n     = {c[6], c[3]};
    e.i2cm_rst_n     = c[4];
    e.usb_rst_n      = c[5];
    e.cpu_core_rst_n = c[11:8];
    return e;
  endfunction

  function automatic irq_out_t expected_irq();
    irq_out_t    e;
    logic [19:0] act;
    act = model_reg[addr_glbl_mask][19:0] & {model_sw_hi, model_hw_stat, model_sw_lo};
    e.irq_lines = act[15:0];
    e.soft_irq  = act[16];
    e.user_irq  = act[19:17];
    return e;
  endfunction

  // Pins held stable, so both sync stages match
  function automatic gpio_cfg_t expected_gpio();
    gpio_cfg_t e;
    e.out_data    = model_reg[addr_gpio_out];
    e.dir_sel     = model_reg[addr_gpio_dir];
    e.out_type    = model_reg[addr_gpio_type];
    e.posedge_sel = model_reg[addr_gpio_pos];
    e.negedge_sel = model_reg[addr_gpio_neg];
    e.data_in     = model_pin;
    e.prev_indata = model_pin;
    return e;
  endfunction

  function automatic string op_name(input logic [2:0] op);
    case (op)
      op_wr:   return "write";
      op_rd:   return "read";
      op_pin:  return "pins";
      op_evt:  return "event";
      op_src:  return "source";
      default: return "unknown";
    endcase
  endfunction

  task automatic model_write(input logic [addr_w-1:0] addr, input logic [be_w-1:0] be,
                             input word_t data);
    case (addr)
      addr_glbl_ctrl, addr_glbl_mask, addr_gpio_out, addr_gpio_dir, addr_gpio_type,
      addr_gpio_mask, addr_gpio_pos, addr_gpio_neg: begin
        model_reg[addr] = merge_bytes(model_reg[addr], data, be);
      end
      addr_glbl_stat: begin
        if (be[0]) model_sw_lo = data[7:0];
        // Hardware byte is write-one-to-clear
        if (be[1]) model_hw_stat = model_hw_stat & ~data[15:8];
        if (be[2]) model_sw_hi = data[19:16];
      end
      addr_gpio_stat: begin
        for (int i = 0; i < be_w; i++) begin
          if (be[i]) model_pstat[8*i +: 8] = model_pstat[8*i +: 8] & ~data[8*i +: 8];
        end
      end
      addr_gpio_set:  model_pstat = model_pstat | data;
      default: ;
    endcase
  endtask

  // Sticky hardware status with the GPIO summary in bit 7 and set winning over clear
  task automatic model_settle();
    model_hw_stat = model_hw_stat |
                    {|(model_pstat & model_reg[addr_gpio_mask]), model_src[6:0]};
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rst(input rst_ctrl_t got, input rst_ctrl_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: rst_ctrl %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_irq(input irq_out_t got, input irq_out_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: irq_out %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_gpio(input gpio_cfg_t got, input gpio_cfg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: gpio_cfg %h, expected %h", $time, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // Bus and table steps
  // --------------------------------------------------------------------------
  // Holds cs through the ack cycle so set and clear strobes see it
  task automatic bus_access(input logic wr, input logic [addr_w-1:0] addr,
                            input logic [be_w-1:0] be, input word_t wdata,
                            output word_t rdata);
    int   waits;
    logic got_ack;
    waits   = 0;
    got_ack = 1'b0;
    @(negedge mclk);
    reg_req.cs    = 1'b1;
    reg_req.wr    = wr;
    reg_req.addr  = addr;
    reg_req.be    = be;
    reg_req.wdata = wdata;
    while (!got_ack && waits < ack_limit) begin
      @(negedge mclk);
      waits++;
      if (reg_ack) got_ack = 1'b1;
    end
    rdata = reg_rdata;
    if (!got_ack) begin
      errors++;
      $display("Bus timeout: no acknowledge from address %0d after %0d cycles", addr, waits);
    end
    @(negedge mclk);
    reg_req = '0;
  endtask

  task automatic add_step(input logic [2:0] op, input logic [addr_w-1:0] addr,
                          input logic [be_w-1:0] be, input word_t data, input word_t exp,
                          input logic rnd, input logic use_model);
    step_t s;
    s.op        = op;
    s.addr      = addr;
    s.be        = be;
    s.data      = data;
    s.exp       = exp;
    s.rnd       = rnd;
    s.use_model = use_model;
    steps.push_back(s);
  endtask

  task automatic build_table();
    logic [addr_w-1:0] plain [8];
    logic [be_w-1:0]   part_be [8];
    logic [addr_w-1:0] unused [3];
    plain   = '{addr_glbl_ctrl, addr_glbl_mask, addr_gpio_out, addr_gpio_dir,
                addr_gpio_type, addr_gpio_mask, addr_gpio_pos, addr_gpio_neg};
    part_be = '{4'h6, 4'h9, 4'h3, 4'hc, 4'h1, 4'h8, 4'h5, 4'ha};
    unused  = '{5'd2, 5'd14, 5'd31};
    // Identity word and unused holes
    add_step(op_rd, addr_chip_id, 4'hf, '0, 32'h8268_2301, 1'b0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      add_step(op_rd, unused[i], 4'hf, '0,           '0, 1'b0, 1'b0);
      add_step(op_wr, unused[i], 4'hf, 32'hffff_ffff, '0, 1'b0, 1'b0);
      add_step(op_rd, unused[i], 4'hf, '0,           '0, 1'b0, 1'b0);
    end
    // Random full and partial writes read back against the model
    for (int i = 0; i < 8; i++) begin
      add_step(op_wr, plain[i], 4'hf,       '0, '0, 1'b1, 1'b0);
      add_step(op_rd, plain[i], 4'hf,       '0, '0, 1'b0, 1'b1);
      add_step(op_wr, plain[i], part_be[i], '0, '0, 1'b1, 1'b0);
      add_step(op_rd, plain[i], 4'hf,       '0, '0, 1'b0, 1'b1);
    end
    // Pin synchroniser
    add_step(op_pin, '0,           4'h0, 32'ha5c3_0f96, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_gpio_in, 4'hf, '0,            32'ha5c3_0f96, 1'b0, 1'b0);
    add_step(op_pin, '0,           4'h0, 32'h5a3c_f069, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_gpio_in, 4'hf, '0,            '0,            1'b0, 1'b1);
    // GPIO status, set, clear and the summary into irq_lines bit 15
    add_step(op_wr,  addr_gpio_mask, 4'hf, 32'h0000_0f0f, '0,            1'b0, 1'b0);
    add_step(op_wr,  addr_glbl_mask, 4'hf, 32'h000f_8000, '0,            1'b0, 1'b0);
    add_step(op_evt, '0,             4'h0, 32'h0000_0101, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_gpio_stat, 4'hf, '0,            32'h0000_0101, 1'b0, 1'b0);
    add_step(op_wr,  addr_gpio_set,  4'hf, 32'h0202_0000, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_gpio_stat, 4'hf, '0,            32'h0202_0101, 1'b0, 1'b0);
    add_step(op_wr,  addr_gpio_stat, 4'h1, 32'h0000_00ff, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_gpio_set,  4'hf, '0,            32'h0202_0100, 1'b0, 1'b0);
    add_step(op_wr,  addr_glbl_stat, 4'h2, 32'h0000_8000, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_stat, 4'hf, '0,            32'h0000_8000, 1'b0, 1'b0);
    add_step(op_wr,  addr_gpio_stat, 4'h2, 32'h0000_0100, '0,            1'b0, 1'b0);
    add_step(op_wr,  addr_glbl_stat, 4'h2, 32'h0000_8000, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_stat, 4'hf, '0,            '0,            1'b0, 1'b0);
    add_step(op_wr,  addr_gpio_stat, 4'hc, 32'h0202_0000, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_gpio_stat, 4'hf, '0,            '0,            1'b0, 1'b0);
    // Hardware source held and released with the gpio_intr field of hw_src ignored
    add_step(op_src, '0,             4'h0, 32'h0000_0084, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_stat, 4'hf, '0,            32'h0000_0400, 1'b0, 1'b0);
    add_step(op_wr,  addr_glbl_stat, 4'h2, 32'h0000_0400, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_stat, 4'hf, '0,            32'h0000_0400, 1'b0, 1'b0);
    add_step(op_src, '0,             4'h0, 32'h0000_0000, '0,            1'b0, 1'b0);
    add_step(op_wr,  addr_glbl_stat, 4'h2, 32'h0000_0400, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_stat, 4'hf, '0,            '0,            1'b0, 1'b0);
    // Software status bits under the mask
    add_step(op_wr,  addr_glbl_stat, 4'h5, 32'h000a_00c3, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_stat, 4'hf, '0,            32'h000a_00c3, 1'b0, 1'b0);
    add_step(op_wr,  addr_glbl_mask, 4'h1, 32'h0000_000f, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_mask, 4'hf, '0,            '0,            1'b0, 1'b1);
    add_step(op_wr,  addr_glbl_stat, 4'h4, 32'h0001_0000, '0,            1'b0, 1'b0);
    add_step(op_rd,  addr_glbl_stat, 4'hf, '0,            32'h0001_00c3, 1'b0, 1'b0);
  endtask

  task automatic apply_step(input step_t st, input int idx);
    word_t     data;
    word_t     rdata;
    word_t     exp;
    gpio_cfg_t exp_cfg;
    int        err_before;
    err_before = errors;
    data       = st.data;
    case (st.op)
      op_wr: begin
        if (st.rnd) data = rand_word();
        bus_access(1'b1, st.addr, st.be, data, rdata);
        model_write(st.addr, st.be, data);
      end
      op_rd: begin
        bus_access(1'b0, st.addr, st.be, '0, rdata);
        exp = st.use_model ? model_read(st.addr) : st.exp;
        check_word($sformatf("address %0d", st.addr), rdata, exp);
      end
      op_pin: begin
        @(negedge mclk);
        gpio_in_data = data;
        // Second stage has the new pins after two edges, third stage not yet
        repeat (2) @(negedge mclk);
        exp_cfg             = expected_gpio();
        exp_cfg.prev_indata = data;
        check_gpio(gpio_cfg, exp_cfg);
        // Third stage follows one edge later
        @(negedge mclk);
        model_pin = data;
        check_gpio(gpio_cfg, expected_gpio());
      end
      op_evt: begin
        @(negedge mclk);
        gpio_int_event = data;
        @(negedge mclk);
        gpio_int_event = '0;
        model_pstat = model_pstat | data;
      end
      op_src: begin
        @(negedge mclk);
        hw_src    = hw_intr_t'(data[7:0]);
        model_src = data[7:0];
      end
      default: begin
        errors++;
        $display("Unknown operation code %0d in step %0d", st.op, idx);
      end
    endcase
    // One more edge so the GPIO summary reaches the global status
    @(negedge mclk);
    model_settle();
    check_rst(rst_ctrl, expected_rst());
    check_irq(irq_out, expected_irq());
    check_gpio(gpio_cfg, expected_gpio());
    $display("step %0d: %s addr %0d be %h data %h : %s", idx, op_name(st.op), st.addr,
             st.be, data, (errors == err_before) ? "ok" : "mismatch");
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    mclk           = 1'b0;
    h_reset_n      = 1'b1;
    reg_req        = '0;
    gpio_in_data   = '0;
    gpio_int_event = '0;
    hw_src         = '0;
    errors         = 0;
    checks         = 0;
    table_ready    = 1'b0;
    lfsr_state     = 32'h6672_15e5;
    for (int i = 0; i < 32; i++) begin
      model_reg[i] = '0;
    end
    model_sw_lo   = '0;
    model_sw_hi   = '0;
    model_hw_stat = '0;
    model_pstat   = '0;
    model_pin     = '0;
    model_src     = '0;
    build_table();
    table_ready = 1'b1;
    // Assert reset before the first rising clock edge
    #1;
    h_reset_n = 1'b0;
    repeat (reset_cycles) @(negedge mclk);
    h_reset_n = 1'b1;
    check_word("reg_ack after reset", word_t'(reg_ack), '0);
    check_word("reg_rdata after reset", reg_rdata, '0);
    for (int i = 0; i < steps.size(); i++) begin
      apply_step(steps[i], i);
    end
    $display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Budget per table entry plus the reset time
  initial begin
    wait (table_ready === 1'b1);
    #(steps.size() * step_budget * clk_ns + reset_cycles * clk_ns);
    $display("Watchdog: run did not complete in time for %0d steps", steps.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: files.f
src/pinmux_pkg.sv
src/intr_stat_reg.sv
src/glbl_ctrl_bank.sv
src/gpio_cfg_bank.sv
src/reg_bus_resp.sv
src/pinmux_regs.sv
bench/pinmux_regs_assertions.sv
bench/pinmux_regs_tb.sv

// File: Bender.yml
package:
  name: pinmux_regs

sources:
  - files:
      - src/pinmux_pkg.sv
      - src/intr_stat_reg.sv
      - src/glbl_ctrl_bank.sv
      - src/gpio_cfg_bank.sv
      - src/reg_bus_resp.sv
      - src/pinmux_regs.sv
  - target: test
    files:
      - bench/pinmux_regs_assertions.sv
      - bench/pinmux_regs_tb.sv
